/* Makefile */
# Verilator simulation of periph_system.
SRCS := $(wildcard verilog/*.sv) $(wildcard tests/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_periph_system
	@out="$$(./obj_dir/Vtb_periph_system)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

obj_dir/Vtb_periph_system: filelist.f $(SRCS)
	verilator --binary --timing -Wno-fatal \
	  --top-module tb_periph_system \
	  -f filelist.f -Mdir obj_dir -o Vtb_periph_system

clean:
	rm -rf obj_dir

/* filelist.f */
verilog/bus_pkg.sv
verilog/dev_bus_if.sv
verilog/sram_ram.sv
verilog/gpio.sv
verilog/pwm.sv
verilog/timer.sv
verilog/bus_xbar.sv
verilog/periph_system.sv
tests/tb_periph_system.sv

/* tests/tb_periph_system.sv */
//////////////////////////////////////////////////////////////////////
// Plays the bus host of periph_system. Stops at the first mismatch.
//////////////////////////////////////////////////////////////////////
module tb_periph_system;

  localparam logic [31:0] SramBase  = 32'h0010_0000;
  localparam logic [31:0] GpioBase  = 32'h8000_0000;
  localparam logic [31:0] PwmBase   = 32'h8000_1000;
  localparam logic [31:0] TimerBase = 32'h8000_2000;
  localparam logic [31:0] NoDevAddr = 32'h4000_0000;
  // Whole sequence needs about 3000 cycles.
  localparam int unsigned MaxCycles = 20000;

  logic        clk_sys_i;
  logic        rst_n_i;
  logic        host_req_i;
  logic [31:0] host_addr_i;
  logic        host_we_i;
  logic [3:0]  host_be_i;
  logic [31:0] host_wdata_i;
  logic        host_gnt_o;
  logic        host_rvalid_o;
  logic [31:0] host_rdata_o;
  logic        host_err_o;
  logic [12:0] gp_i;
  logic [23:0] gp_o;
  logic [11:0] pwm_o;
  logic        timer_irq_o;

  // Reference model state.
  logic [31:0] sram_m [1024];
  logic [23:0] gpo_m;
  logic [12:0] gpi_m;
  logic [7:0]  duty_m [12];
  logic [63:0] mtimecmp_m;

  // Pending responses, oldest first.
  logic [31:0] exp_data_q [$];
  logic        exp_err_q [$];
  logic        exp_chk_q [$];
  logic [31:0] cap_q [$];

  logic        acc_seen;
  // Set once the grant has first come up after reset.
  logic        gnt_up = 1'b0;
  int unsigned cycle_cnt = 0;

  periph_system dut_i (
    .clk_sys_i    (clk_sys_i),
    .rst_n_i      (rst_n_i),
    .host_req_i   (host_req_i),
    .host_addr_i  (host_addr_i),
    .host_we_i    (host_we_i),
    .host_be_i    (host_be_i),
    .host_wdata_i (host_wdata_i),
    .host_gnt_o   (host_gnt_o),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .gp_i         (gp_i),
    .gp_o         (gp_o),
    .pwm_o        (pwm_o),
    .timer_irq_o  (timer_irq_o)
  );

  initial begin
    clk_sys_i = 1'b0;
    forever #50 clk_sys_i = ~clk_sys_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers and reference model.
  //////////////////////////////////////////////////////////////////////

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      stop_fail($sformatf("Wrong value on %s", name));
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Address map and register rules. Reads of mtime are not predicted.
  function automatic void ref_access(input  logic [31:0] addr,
                                     input  logic        we,
                                     input  logic [3:0]  be,
                                     input  logic [31:0] wdata,
                                     output logic [31:0] data,
                                     output logic        err,
                                     output logic        chk);
    logic [31:0] win;
    logic [9:0]  widx;
    logic [31:0] gpo_w;
    win  = addr & 32'hFFFF_F000;
    widx = addr[11:2];
    data = '0;
    err  = 1'b0;
    chk  = 1'b1;
    if (win == SramBase) begin
      if (we) begin
        sram_m[widx] = merge_bytes(sram_m[widx], wdata, be);
      end else begin
        data = sram_m[widx];
      end
    end else if (win == GpioBase) begin
      if (we && widx == 10'd0) begin
        gpo_w = merge_bytes({8'h00, gpo_m}, wdata, be);
        gpo_m = gpo_w[23:0];
      end else if (!we && widx == 10'd0) begin
        data = {8'h00, gpo_m};
      end else if (!we && widx == 10'd1) begin
        data = {19'h0, gpi_m};
      end
    end else if (win == PwmBase) begin
      if (widx < 10'd12 && we) begin
        duty_m[widx] = wdata[7:0];
      end else if (widx < 10'd12) begin
        data = {24'h0, duty_m[widx]};
      end
    end else if (win == TimerBase) begin
      if (we && widx == 10'd2) begin
        mtimecmp_m[31:0] = wdata;
      end else if (we && widx == 10'd3) begin
        mtimecmp_m[63:32] = wdata;
      end else if (!we && widx < 10'd2) begin
        chk = 1'b0;
      end else if (!we && widx == 10'd2) begin
        data = mtimecmp_m[31:0];
      end else if (!we && widx == 10'd3) begin
        data = mtimecmp_m[63:32];
      end
    end else begin
      err = 1'b1;
    end
  endfunction

  // Called on a rising edge. Returns on the edge that accepts the request.
  task automatic send_request(input logic [31:0] addr, input logic we,
                              input logic [3:0] be, input logic [31:0] wdata);
    logic [31:0] d;
    logic        e;
    logic        c;
    ref_access(addr, we, be, wdata, d, e, c);
    exp_data_q.push_back(d);
    exp_err_q.push_back(e);
    exp_chk_q.push_back(c);
    host_req_i   <= 1'b1;
    host_addr_i  <= addr;
    host_we_i    <= we;
    host_be_i    <= be;
    host_wdata_i <= wdata;
    @(posedge clk_sys_i);
    while (!host_gnt_o) @(posedge clk_sys_i);
  endtask

  task automatic release_bus();
    host_req_i <= 1'b0;
    host_we_i  <= 1'b0;
  endtask

  task automatic wait_responses();
    while (exp_data_q.size() != 0) @(posedge clk_sys_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Response checking and timeout.
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_sys_i) begin
    acc_seen  <= host_req_i & host_gnt_o;
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      stop_fail("Timeout: the test sequence did not finish within the cycle limit");
    end
  end

  // Responses are due exactly one cycle after acceptance.
  always @(negedge clk_sys_i) begin
    logic [31:0] d;
    logic        e;
    logic        c;
    if (rst_n_i) begin
      if (gnt_up) begin
        check_val("host_gnt_o", host_gnt_o, 1'b1);
      end
      check_val("host_rvalid_o", host_rvalid_o, acc_seen);
      if (host_rvalid_o && exp_data_q.size() == 0) begin
        stop_fail("A response arrived with no request pending");
      end
      if (host_rvalid_o) begin
        d = exp_data_q.pop_front();
        e = exp_err_q.pop_front();
        c = exp_chk_q.pop_front();
        check_val("host_err_o", host_err_o, e);
        if (c) begin
          check_val("host_rdata_o", host_rdata_o, d);
        end else begin
          cap_q.push_back(host_rdata_o);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence.
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [63:0] mt;
    int unsigned gap;
    int unsigned t_read;
    int unsigned cnt [12];
    rnd = $urandom(32'h1801_fcf5);
    rst_n_i      <= 1'b0;
    host_req_i   <= 1'b0;
    host_addr_i  <= '0;
    host_we_i    <= 1'b0;
    host_be_i    <= '0;
    host_wdata_i <= '0;
    gp_i         <= '0;
    gpo_m      = '0;
    gpi_m      = '0;
    mtimecmp_m = '1;
    for (int ch = 0; ch < 12; ch++) begin
      duty_m[ch] = '0;
    end
    repeat (8) @(posedge clk_sys_i);
    check_val("host_gnt_o", host_gnt_o, 1'b0);
    rst_n_i <= 1'b1;
    @(negedge clk_sys_i);
    check_val("host_rvalid_o", host_rvalid_o, 1'b0);
    check_val("host_err_o", host_err_o, 1'b0);
    check_val("gp_o", gp_o, '0);
    check_val("pwm_o", pwm_o, '0);
    check_val("timer_irq_o", timer_irq_o, 1'b0);
    @(posedge clk_sys_i);
    while (!host_gnt_o) @(posedge clk_sys_i);
    gnt_up = 1'b1;

    // SRAM filled whole first, so every word read back is defined.
    for (int j = 0; j < 1024; j++) begin
      send_request(SramBase + 32'(4 * j), 1'b1, 4'hf, $urandom());
    end
    for (int j = 0; j < 200; j++) begin
      rnd = $urandom();
      send_request(SramBase + 32'd4 * $urandom_range(0, 1023), 1'b1, rnd[3:0], $urandom());
    end
    for (int j = 0; j < 1024; j++) begin
      send_request(SramBase + 32'(4 * j), 1'b0, 4'hf, 32'h0);
    end
    release_bus();
    wait_responses();

    // GPIO outputs with partial byte enables, then the inputs.
    send_request(GpioBase, 1'b1, 4'hf, $urandom());
    for (int k = 0; k < 8; k++) begin
      rnd = $urandom();
      send_request(GpioBase, 1'b1, rnd[3:0], $urandom());
      send_request(GpioBase, 1'b0, 4'hf, 32'h0);
      release_bus();
      wait_responses();
      check_val("gp_o", gp_o, gpo_m);
    end
    rnd = $urandom();
    gp_i  <= rnd[12:0];
    gpi_m  = rnd[12:0];
    repeat (4) @(posedge clk_sys_i);
    send_request(GpioBase + 32'h4, 1'b0, 4'hf, 32'h0);
    release_bus();
    wait_responses();

    // PWM duties, then one full counter period.
    for (int ch = 0; ch < 12; ch++) begin
      send_request(PwmBase + 32'(4 * ch), 1'b1, 4'hf, $urandom());
    end
    for (int ch = 0; ch < 12; ch++) begin
      send_request(PwmBase + 32'(4 * ch), 1'b0, 4'hf, 32'h0);
    end
    release_bus();
    wait_responses();
    for (int ch = 0; ch < 12; ch++) begin
      cnt[ch] = 0;
    end
    repeat (256) begin
      @(negedge clk_sys_i);
      for (int ch = 0; ch < 12; ch++) begin
        cnt[ch] += pwm_o[ch];
      end
    end
    for (int ch = 0; ch < 12; ch++) begin
      check_val($sformatf("pwm_o[%0d] high cycles", ch), cnt[ch], duty_m[ch]);
    end
    @(posedge clk_sys_i);

    // Two mtime reads accepted gap cycles apart.
    gap = $urandom_range(5, 40);
    send_request(TimerBase, 1'b0, 4'hf, 32'h0);
    release_bus();
    repeat (gap - 1) @(posedge clk_sys_i);
    send_request(TimerBase, 1'b0, 4'hf, 32'h0);
    release_bus();
    wait_responses();
    if (cap_q.size() != 2) begin
      stop_fail("Expected two captured mtime values");
    end
    t0 = cap_q.pop_front();
    t1 = cap_q.pop_front();
    check_val("mtime low delta", t1 - t0, gap);

    // Compare value 60 ticks after the mtime read.
    send_request(TimerBase, 1'b0, 4'hf, 32'h0);
    t_read = cycle_cnt;
    send_request(TimerBase + 32'h4, 1'b0, 4'hf, 32'h0);
    release_bus();
    wait_responses();
    t0 = cap_q.pop_front();
    t1 = cap_q.pop_front();
    mt = {t1, t0} + 64'd60;
    send_request(TimerBase + 32'h8, 1'b1, 4'hf, mt[31:0]);
    send_request(TimerBase + 32'hc, 1'b1, 4'hf, mt[63:32]);
    send_request(TimerBase + 32'h8, 1'b0, 4'hf, 32'h0);
    send_request(TimerBase + 32'hc, 1'b0, 4'hf, 32'h0);
    release_bus();
    wait_responses();
    while (cycle_cnt - t_read < 50) begin
      @(negedge clk_sys_i);
      check_val("timer_irq_o", timer_irq_o, 1'b0);
    end
    while (cycle_cnt - t_read < 70) @(negedge clk_sys_i);
    check_val("timer_irq_o", timer_irq_o, 1'b1);
    @(posedge clk_sys_i);

    // Unmapped window.
    send_request(NoDevAddr, 1'b0, 4'hf, 32'h0);
    send_request(NoDevAddr + 32'h10, 1'b1, 4'hf, $urandom());
    release_bus();
    wait_responses();

    if (cap_q.size() != 0) begin
      stop_fail("Captured read data was left over at the end");
    end
    $display("Everything OK");
    $finish;
  end

endmodule

/* verilog/bus_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Address map assumes 4 KiB device windows and a 32-bit data bus.
// GPIO widths must not exceed the bus data width.
//////////////////////////////////////////////////////////////////////
package bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths.
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned BusAddrWidth  = 32;
  localparam int unsigned BusDataWidth  = 32;
  localparam int unsigned BusByteEnable = 4;

  // Byte offset inside one device window.
  localparam int unsigned DevAddrWidth = 12;
  localparam int unsigned DevWordWidth = DevAddrWidth - 2;
  localparam int unsigned SramWords    = 2 ** DevWordWidth;

  //////////////////////////////////////////////////////////////////////
  // Address map.
  //////////////////////////////////////////////////////////////////////

  localparam logic [BusAddrWidth-1:0] SramBase  = 32'h0010_0000;
  localparam logic [BusAddrWidth-1:0] GpioBase  = 32'h8000_0000;
  localparam logic [BusAddrWidth-1:0] PwmBase   = 32'h8000_1000;
  localparam logic [BusAddrWidth-1:0] TimerBase = 32'h8000_2000;

  localparam logic [BusAddrWidth-1:0] WindowMask =
      {{(BusAddrWidth - DevAddrWidth){1'b1}}, {DevAddrWidth{1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // Device widths and register word indices.
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned GpiWidth   = 13;
  localparam int unsigned GpoWidth   = 24;
  localparam int unsigned PwmWidth   = 12;
  localparam int unsigned PwmCtrSize = 8;

  localparam logic [DevWordWidth-1:0] GpioOutIdx    = 10'd0;
  localparam logic [DevWordWidth-1:0] GpioInIdx     = 10'd1;
  localparam logic [DevWordWidth-1:0] MtimeLoIdx    = 10'd0;
  localparam logic [DevWordWidth-1:0] MtimeHiIdx    = 10'd1;
  localparam logic [DevWordWidth-1:0] MtimecmpLoIdx = 10'd2;
  localparam logic [DevWordWidth-1:0] MtimecmpHiIdx = 10'd3;

  // Decoded target of a host access.
  typedef enum logic [2:0] {
    Sram,
    Gpio,
    Pwm,
    Timer,
    NoDev
  } dev_sel_e;

endpackage

/* verilog/bus_xbar.sv */
//////////////////////////////////////////////////////////////////////
// Single host, no arbitration. Unmapped accesses answer with err set.
//////////////////////////////////////////////////////////////////////
module bus_xbar (
  input  logic                               clk_sys_i,
  input  logic                               rst_n_i,

  input  logic                               host_req_i,
  input  logic [bus_pkg::BusAddrWidth-1:0]   host_addr_i,
  input  logic                               host_we_i,
  input  logic [bus_pkg::BusByteEnable-1:0]  host_be_i,
  input  logic [bus_pkg::BusDataWidth-1:0]   host_wdata_i,
  output logic                               host_gnt_o,
  output logic                               host_rvalid_o,
  output logic [bus_pkg::BusDataWidth-1:0]   host_rdata_o,
  output logic                               host_err_o,

  dev_bus_if.host                            sram_o,
  dev_bus_if.host                            gpio_o,
  dev_bus_if.host                            pwm_o,
  dev_bus_if.host                            timer_o
);
  import bus_pkg::*;

  logic                    gnt_q;
  logic                    acc;
  logic                    acc_q;
  dev_sel_e                sel;
  dev_sel_e                sel_q;
  logic                    dev_rvalid;
  logic                    dev_err;
  logic [BusDataWidth-1:0] dev_rdata;

  assign host_gnt_o = gnt_q;
  assign acc        = host_req_i & gnt_q;

  //////////////////////////////////////////////////////////////////////
  // Request path.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if ((host_addr_i & WindowMask) == SramBase) begin
      sel = Sram;
    end else if ((host_addr_i & WindowMask) == GpioBase) begin
      sel = Gpio;
    end else if ((host_addr_i & WindowMask) == PwmBase) begin
      sel = Pwm;
    end else if ((host_addr_i & WindowMask) == TimerBase) begin
      sel = Timer;
    end else begin
      sel = NoDev;
    end
  end

  // Only the selected device sees req.
  assign sram_o.req  = acc & (sel == Sram);
  assign gpio_o.req  = acc & (sel == Gpio);
  assign pwm_o.req   = acc & (sel == Pwm);
  assign timer_o.req = acc & (sel == Timer);

  assign sram_o.we    = host_we_i;
  assign sram_o.addr  = host_addr_i[DevAddrWidth-1:0];
  assign sram_o.be    = host_be_i;
  assign sram_o.wdata = host_wdata_i;
  assign gpio_o.we    = host_we_i;
  assign gpio_o.addr  = host_addr_i[DevAddrWidth-1:0];
  assign gpio_o.be    = host_be_i;
  assign gpio_o.wdata = host_wdata_i;
  assign pwm_o.we     = host_we_i;
  assign pwm_o.addr   = host_addr_i[DevAddrWidth-1:0];
  assign pwm_o.be     = host_be_i;
  assign pwm_o.wdata  = host_wdata_i;
  assign timer_o.we    = host_we_i;
  assign timer_o.addr  = host_addr_i[DevAddrWidth-1:0];
  assign timer_o.be    = host_be_i;
  assign timer_o.wdata = host_wdata_i;

  //////////////////////////////////////////////////////////////////////
  // Response path.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gnt_q <= 1'b0;
      acc_q <= 1'b0;
      sel_q <= NoDev;
    end else begin
      gnt_q <= 1'b1;
      acc_q <= acc;
      sel_q <= sel;
    end
  end

  always_comb begin
    dev_rvalid = 1'b1;
    dev_rdata  = '0;
    dev_err    = 1'b1;
    case (sel_q)
      Sram: begin
        dev_rvalid = sram_o.rvalid;
        dev_rdata  = sram_o.rdata;
        dev_err    = sram_o.err;
      end
      Gpio: begin
        dev_rvalid = gpio_o.rvalid;
        dev_rdata  = gpio_o.rdata;
        dev_err    = gpio_o.err;
      end
      Pwm: begin
        dev_rvalid = pwm_o.rvalid;
        dev_rdata  = pwm_o.rdata;
        dev_err    = pwm_o.err;
      end
      Timer: begin
        dev_rvalid = timer_o.rvalid;
        dev_rdata  = timer_o.rdata;
        dev_err    = timer_o.err;
      end
      default: ;
    endcase
  end

  assign host_rvalid_o = acc_q & dev_rvalid;
  assign host_rdata_o  = dev_rdata;
  assign host_err_o    = acc_q & dev_err;

endmodule

/* verilog/dev_bus_if.sv */
//////////////////////////////////////////////////////////////////////
// Devices answer every request exactly one cycle later.
//////////////////////////////////////////////////////////////////////
interface dev_bus_if;
  import bus_pkg::*;

  // Request side, driven by the decoder.
  logic                     req;
  logic                     we;
  logic [DevAddrWidth-1:0]  addr;
  logic [BusByteEnable-1:0] be;
  logic [BusDataWidth-1:0]  wdata;

  // Response side, driven by the device.
  logic                     rvalid;
  logic [BusDataWidth-1:0]  rdata;
  logic                     err;

  // No device reports errors.
  assign err = 1'b0;

  modport host (
    output req, we, addr, be, wdata,
    input  rvalid, rdata, err
  );

  modport device (
    input  req, we, addr, be, wdata,
    output rvalid, rdata
  );

endinterface

/* verilog/gpio.sv */
//////////////////////////////////////////////////////////////////////
// Inputs pass a two-flop synchroniser, so reads lag the pins.
//////////////////////////////////////////////////////////////////////
module gpio #(
  parameter int unsigned GpiWidth = bus_pkg::GpiWidth,
  parameter int unsigned GpoWidth = bus_pkg::GpoWidth
) (
  input  logic                clk_sys_i,
  input  logic                rst_n_i,
  dev_bus_if.device           bus_i,
  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o
);
  import bus_pkg::*;

  logic [GpoWidth-1:0]     gpo_q;
  logic [GpiWidth-1:0]     gpi_meta_q;
  logic [GpiWidth-1:0]     gpi_q;
  logic [DevWordWidth-1:0] word_idx;
  logic [BusDataWidth-1:0] gpo_word;
  logic [BusDataWidth-1:0] gpo_next;
  logic [BusDataWidth-1:0] gpi_word;
  logic                    rvalid_q;
  logic [BusDataWidth-1:0] rdata_q;

  assign word_idx = bus_i.addr[DevAddrWidth-1:2];

  always_comb begin
    gpo_word = '0;
    gpi_word = '0;
    gpo_word[GpoWidth-1:0] = gpo_q;
    gpi_word[GpiWidth-1:0] = gpi_q;
    gpo_next = gpo_word;
    for (int b = 0; b < BusByteEnable; b++) begin
      if (bus_i.be[b]) begin
        gpo_next[8*b +: 8] = bus_i.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_q      <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_q      <= gpi_meta_q;
      rvalid_q   <= bus_i.req;
      if (bus_i.req && bus_i.we && word_idx == GpioOutIdx) begin
        gpo_q <= gpo_next[GpoWidth-1:0];
      end
    end
  end

  // Read data, zero for writes and unused offsets.
  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      if (bus_i.we) begin
        rdata_q <= '0;
      end else if (word_idx == GpioOutIdx) begin
        rdata_q <= gpo_word;
      end else if (word_idx == GpioInIdx) begin
        rdata_q <= gpi_word;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign gp_o         = gpo_q;

endmodule

/* verilog/periph_system.sv */
//////////////////////////////////////////////////////////////////////
// One bus host. host_gnt_o rises the cycle after reset is released.
//////////////////////////////////////////////////////////////////////
module periph_system (
  input  logic                               clk_sys_i,
  input  logic                               rst_n_i,

  // Host port.
  input  logic                               host_req_i,
  input  logic [bus_pkg::BusAddrWidth-1:0]   host_addr_i,
  input  logic                               host_we_i,
  input  logic [bus_pkg::BusByteEnable-1:0]  host_be_i,
  input  logic [bus_pkg::BusDataWidth-1:0]   host_wdata_i,
  output logic                               host_gnt_o,
  output logic                               host_rvalid_o,
  output logic [bus_pkg::BusDataWidth-1:0]   host_rdata_o,
  output logic                               host_err_o,

  // Pins.
  input  logic [bus_pkg::GpiWidth-1:0]       gp_i,
  output logic [bus_pkg::GpoWidth-1:0]       gp_o,
  output logic [bus_pkg::PwmWidth-1:0]       pwm_o,
  output logic                               timer_irq_o
);
  import bus_pkg::*;

  dev_bus_if sram_bus ();
  dev_bus_if gpio_bus ();
  dev_bus_if pwm_bus ();
  dev_bus_if timer_bus ();

  bus_xbar u_xbar (
    .clk_sys_i    (clk_sys_i),
    .rst_n_i      (rst_n_i),
    .host_req_i   (host_req_i),
    .host_addr_i  (host_addr_i),
    .host_we_i    (host_we_i),
    .host_be_i    (host_be_i),
    .host_wdata_i (host_wdata_i),
    .host_gnt_o   (host_gnt_o),
    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o),
    .sram_o       (sram_bus),
    .gpio_o       (gpio_bus),
    .pwm_o        (pwm_bus),
    .timer_o      (timer_bus)
  );

  sram_ram u_sram (
    .clk_sys_i(clk_sys_i),
    .bus_i    (sram_bus)
  );

  gpio #(
    .GpiWidth ( GpiWidth ),
    .GpoWidth ( GpoWidth )
  ) u_gpio (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .bus_i    (gpio_bus),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  pwm #(
    .PwmWidth   ( PwmWidth   ),
    .PwmCtrSize ( PwmCtrSize )
  ) u_pwm (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .bus_i    (pwm_bus),
    .pwm_o    (pwm_o)
  );

  timer u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_n_i    (rst_n_i),
    .bus_i      (timer_bus),
    .timer_irq_o(timer_irq_o)
  );

endmodule

/* verilog/pwm.sv */
//////////////////////////////////////////////////////////////////////
// All channels share one counter. Duty writes are whole-word.
//////////////////////////////////////////////////////////////////////
module pwm #(
  parameter int unsigned PwmWidth   = bus_pkg::PwmWidth,
  parameter int unsigned PwmCtrSize = bus_pkg::PwmCtrSize
) (
  input  logic                clk_sys_i,
  input  logic                rst_n_i,
  dev_bus_if.device           bus_i,
  output logic [PwmWidth-1:0] pwm_o
);
  import bus_pkg::*;

  logic [PwmCtrSize-1:0]   duty_q [PwmWidth];
  logic [PwmCtrSize-1:0]   ctr_q;
  logic [DevWordWidth-1:0] word_idx;
  logic [BusDataWidth-1:0] rdata_d;
  logic                    rvalid_q;
  logic [BusDataWidth-1:0] rdata_q;

  assign word_idx = bus_i.addr[DevAddrWidth-1:2];

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctr_q    <= '0;
      rvalid_q <= 1'b0;
      for (int i = 0; i < PwmWidth; i++) begin
        duty_q[i] <= '0;
      end
    end else begin
      // Wraps every 2^PwmCtrSize cycles.
      ctr_q    <= ctr_q + 1'b1;
      rvalid_q <= bus_i.req;
      for (int i = 0; i < PwmWidth; i++) begin
        if (bus_i.req && bus_i.we && word_idx == DevWordWidth'(i)) begin
          duty_q[i] <= bus_i.wdata[PwmCtrSize-1:0];
        end
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    for (int i = 0; i < PwmWidth; i++) begin
      if (!bus_i.we && word_idx == DevWordWidth'(i)) begin
        rdata_d[PwmCtrSize-1:0] = duty_q[i];
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  // High while the counter is below the duty.
  for (genvar i = 0; i < PwmWidth; i++) begin : gen_chan
    assign pwm_o[i] = (ctr_q < duty_q[i]);
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;

endmodule

/* verilog/sram_ram.sv */
//////////////////////////////////////////////////////////////////////
// 4 KiB, contents undefined until written. Writes return zero data.
//////////////////////////////////////////////////////////////////////
module sram_ram (
  input  logic        clk_sys_i,
  dev_bus_if.device   bus_i
);
  import bus_pkg::*;

  logic [BusDataWidth-1:0] mem [SramWords];
  logic [DevWordWidth-1:0] word_idx;
  logic                    rvalid_q;
  logic [BusDataWidth-1:0] rdata_q;

  // Byte offset bits are ignored.
  assign word_idx = bus_i.addr[DevAddrWidth-1:2];

  // Byte-enable writes.
  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req && bus_i.we) begin
      for (int b = 0; b < BusByteEnable; b++) begin
        if (bus_i.be[b]) begin
          mem[word_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    rvalid_q <= bus_i.req;
    if (bus_i.req) begin
      rdata_q <= bus_i.we ? '0 : mem[word_idx];
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;

endmodule

/* verilog/timer.sv */
//////////////////////////////////////////////////////////////////////
// Registers are written whole-word; byte enables are ignored.
//////////////////////////////////////////////////////////////////////
module timer (
  input  logic       clk_sys_i,
  input  logic       rst_n_i,
  dev_bus_if.device  bus_i,
  output logic       timer_irq_o
);
  import bus_pkg::*;

  logic [63:0]             mtime_q;
  logic [63:0]             mtime_d;
  logic [63:0]             mtimecmp_q;
  logic [63:0]             mtimecmp_d;
  logic                    irq_q;
  logic                    wr;
  logic [DevWordWidth-1:0] word_idx;
  logic                    rvalid_q;
  logic [BusDataWidth-1:0] rdata_q;

  assign word_idx = bus_i.addr[DevAddrWidth-1:2];
  assign wr       = bus_i.req & bus_i.we;

  //////////////////////////////////////////////////////////////////////
  // Counter and compare registers.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    if (wr) begin
      case (word_idx)
        MtimeLoIdx:    mtime_d[31:0]     = bus_i.wdata;
        MtimeHiIdx:    mtime_d[63:32]    = bus_i.wdata;
        MtimecmpLoIdx: mtimecmp_d[31:0]  = bus_i.wdata;
        MtimecmpHiIdx: mtimecmp_d[63:32] = bus_i.wdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      // One cycle behind the compare.
      irq_q      <= (mtime_q >= mtimecmp_q);
      rvalid_q   <= bus_i.req;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read data.
  //////////////////////////////////////////////////////////////////////

  // Samples the values of the request cycle.
  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      if (bus_i.we) begin
        rdata_q <= '0;
      end else begin
        case (word_idx)
          MtimeLoIdx:    rdata_q <= mtime_q[31:0];
          MtimeHiIdx:    rdata_q <= mtime_q[63:32];
          MtimecmpLoIdx: rdata_q <= mtimecmp_q[31:0];
          MtimecmpHiIdx: rdata_q <= mtimecmp_q[63:32];
          default:       rdata_q <= '0;
        endcase
      end
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign timer_irq_o  = irq_q;

endmodule
